//--- verilog/core_mem_pkg.sv
//**********************************************************
// Core memory port shared types
// Requestor-side request and response structs, the packed
// AXI channel bundles and the access size encoding
//**********************************************************

package core_mem_pkg;

    parameter int PADDR_WIDTH = 32; // Physical address width

    typedef logic [31:0] word_t;
    typedef logic [PADDR_WIDTH-1:0] paddr_t;

    // Access size, also used to pick strobes and read lanes
    typedef enum logic [1:0] {
        SIZE_BYTE     = 2'b00,
        SIZE_HALFWORD = 2'b01,
        SIZE_WORD     = 2'b10
    } size_e;

    // One requestor's request
    // Fields stay stable from valid until the ready pulse
    typedef struct packed {
        logic   valid;
        logic   wen_nren; // High for a write, low for a read
        size_e  size;
        paddr_t addr;     // Byte address, low bits pick the lane
        word_t  wdata;    // Right-aligned store data
    } limp_req_t;

    // Response back to one requestor
    typedef struct packed {
        logic  ready;     // One-cycle pulse at completion
        word_t rdata;     // Zero-extended, valid with ready
    } limp_rsp_t;

    // Signals driven by the manager side of the AXI port
    typedef struct packed {
        logic       arvalid;
        paddr_t     araddr;
        logic       rready;
        logic       awvalid;
        paddr_t     awaddr;
        logic       wvalid;
        word_t      wdata;
        logic [3:0] wstrb;  // One bit per byte lane
    } axi_mreq_t;

    // Signals driven by the slave side
    // No bready here, the manager always accepts B at once
    typedef struct packed {
        logic  arready;
        logic  rvalid;
        word_t rdata;
        logic  awready;
        logic  wready;
        logic  bvalid;
    } axi_srsp_t;

endpackage : core_mem_pkg

//--- verilog/axi_sram_slave.sv
//**********************************************************
// AXI SRAM slave
// Word-wide on-chip memory behind a single-beat AXI port,
// byte strobes on writes and a fixed read latency
//**********************************************************

`timescale 1ns/1ps

module axi_sram_slave #(
    parameter int READ_LATENCY = 2,  // At least 1
    parameter int MEM_WORDS    = 256
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  core_mem_pkg::axi_mreq_t axi_req,
    output core_mem_pkg::axi_srsp_t axi_rsp
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int LAT_W = $clog2(READ_LATENCY + 1);

    core_mem_pkg::word_t mem [MEM_WORDS];

    // Read side
    logic                rd_pending;  // AR taken, R not yet accepted
    logic [LAT_W-1:0]    lat_cnt;
    logic                rvalid_q;
    core_mem_pkg::word_t rdata_q;
    logic [IDX_W-1:0]    rd_idx_q;

    // Write side holding registers
    logic                aw_held;
    logic                w_held;
    logic [IDX_W-1:0]    wr_idx_q;
    core_mem_pkg::word_t wdata_q;
    logic [3:0]          wstrb_q;
    logic                wr_commit;

    // Word index, address modulo the memory size
    function automatic logic [IDX_W-1:0] word_index(input core_mem_pkg::paddr_t addr);
        return IDX_W'(addr[core_mem_pkg::PADDR_WIDTH-1:2] % MEM_WORDS);
    endfunction

    assign wr_commit = aw_held && w_held;

    assign axi_rsp.arready = !rd_pending;
    assign axi_rsp.rvalid  = rvalid_q;
    assign axi_rsp.rdata   = rdata_q;
    assign axi_rsp.awready = !aw_held;
    assign axi_rsp.wready  = !w_held;
    assign axi_rsp.bvalid  = wr_commit; // Single cycle, both holds clear on it

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            rd_pending <= 1'b0;
            rvalid_q   <= 1'b0;
            lat_cnt    <= '0;
        end else if (axi_req.arvalid && !rd_pending) begin
            rd_pending <= 1'b1;
            lat_cnt    <= LAT_W'(READ_LATENCY);
        end else if (rvalid_q && axi_req.rready) begin
            rd_pending <= 1'b0;
            rvalid_q   <= 1'b0;
        end else if (rd_pending && !rvalid_q) begin
            lat_cnt <= lat_cnt - 1'b1;
            if (lat_cnt == LAT_W'(1)) rvalid_q <= 1'b1; // Latency used up
        end
    end

    always_ff @(posedge i_clk) begin
        if (axi_req.arvalid && !rd_pending) begin
            rd_idx_q <= word_index(axi_req.araddr);
        end
        if (rd_pending && !rvalid_q && lat_cnt == LAT_W'(1)) begin
            rdata_q <= mem[rd_idx_q]; // Sampled as rvalid rises
        end
    end

    // AW and W captured independently, in either order
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else if (wr_commit) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            if (axi_req.awvalid && !aw_held) aw_held <= 1'b1;
            if (axi_req.wvalid && !w_held)   w_held  <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (axi_req.awvalid && !aw_held) wr_idx_q <= word_index(axi_req.awaddr);
        if (axi_req.wvalid && !w_held) begin
            wdata_q <= axi_req.wdata;
            wstrb_q <= axi_req.wstrb;
        end
    end

    // Memory starts cleared, writes land lane by lane
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_commit) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb_q[b]) mem[wr_idx_q][b*8 +: 8] <= wdata_q[b*8 +: 8];
            end
        end
    end

endmodule : axi_sram_slave

//--- verilog/core_axi_manager.sv
//**********************************************************
// Core AXI manager
// Fixed-priority arbiter over the requestor ports, held for
// a whole transaction, and a single-beat AXI state machine
// with byte-lane strobes and read-lane extraction
//**********************************************************

`timescale 1ns/1ps

module core_axi_manager #(
    parameter int NUM_REQUESTORS = 3
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  core_mem_pkg::limp_req_t limp_req [NUM_REQUESTORS-1:0],
    output core_mem_pkg::limp_rsp_t limp_rsp [NUM_REQUESTORS-1:0],
    output core_mem_pkg::axi_mreq_t axi_req,
    input  core_mem_pkg::axi_srsp_t axi_rsp
);

    localparam int GNT_W = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

    typedef enum logic [2:0] {
        IDLE,
        SEND_RADDR,
        GET_RDATA,
        SEND_WADDR,
        SEND_WDATA,
        GET_BRESP
    } state_e;

    state_e                  state;
    state_e                  next_state;
    logic [GNT_W-1:0]        sel_idx;    // Lowest valid requestor
    logic [GNT_W-1:0]        grant_q;    // Owner of the running transaction
    logic                    any_valid;
    logic                    w_sent_q;   // W beat went out before AW
    logic                    done;       // Final handshake of the transaction
    core_mem_pkg::limp_req_t cur_req;
    logic [4:0]              lane_shift;
    core_mem_pkg::word_t     rd_shifted;
    core_mem_pkg::word_t     rd_data;

    // Channel handshakes
    logic ar_xfer;
    logic r_xfer;
    logic aw_xfer;
    logic w_xfer;

    assign ar_xfer = axi_req.arvalid && axi_rsp.arready;
    assign r_xfer  = axi_req.rready  && axi_rsp.rvalid;
    assign aw_xfer = axi_req.awvalid && axi_rsp.awready;
    assign w_xfer  = axi_req.wvalid  && axi_rsp.wready;

    // Priority encoder, scanned from the top so index 0 wins
    always_comb begin
        sel_idx   = '0;
        any_valid = 1'b0;
        for (int i = NUM_REQUESTORS - 1; i >= 0; i--) begin
            if (limp_req[i].valid) begin
                sel_idx   = GNT_W'(i);
                any_valid = 1'b1;
            end
        end
    end

    // Grant only moves while idle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            grant_q <= '0;
        end else if (state == IDLE && any_valid) begin
            grant_q <= sel_idx;
        end
    end

    assign cur_req = limp_req[grant_q]; // Held stable by the requestor until ready

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state    <= IDLE;
            w_sent_q <= 1'b0;
        end else begin
            state <= next_state;
            if (state == SEND_WADDR && w_xfer) begin
                w_sent_q <= 1'b1;
            end else if (state != SEND_WADDR) begin
                w_sent_q <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (any_valid) begin
                    next_state = limp_req[sel_idx].wen_nren ? SEND_WADDR : SEND_RADDR;
                end
            end
            SEND_RADDR: if (ar_xfer) next_state = GET_RDATA;
            GET_RDATA:  if (r_xfer)  next_state = IDLE;
            SEND_WADDR: begin
                // AW and W go out together, W may finish first
                if (aw_xfer && (w_xfer || w_sent_q)) begin
                    next_state = GET_BRESP;
                end else if (aw_xfer) begin
                    next_state = SEND_WDATA;
                end
            end
            SEND_WDATA: if (w_xfer) next_state = GET_BRESP;
            GET_BRESP:  if (axi_rsp.bvalid) next_state = IDLE; // bready is implied high
            default:    next_state = IDLE;
        endcase
    end

    // Valids straight from state
    assign axi_req.arvalid = (state == SEND_RADDR);
    assign axi_req.rready  = (state == GET_RDATA);
    assign axi_req.awvalid = (state == SEND_WADDR);
    assign axi_req.wvalid  = (state == SEND_WADDR && !w_sent_q) || (state == SEND_WDATA);

    assign done = r_xfer || (state == GET_BRESP && axi_rsp.bvalid);

    // Word-aligned addresses, sub-word handled by strobes and lanes
    assign axi_req.araddr = {cur_req.addr[core_mem_pkg::PADDR_WIDTH-1:2], 2'b00};
    assign axi_req.awaddr = {cur_req.addr[core_mem_pkg::PADDR_WIDTH-1:2], 2'b00};

    always_comb begin
        unique case (cur_req.size)
            core_mem_pkg::SIZE_BYTE: begin
                axi_req.wstrb = 4'b0001 << cur_req.addr[1:0];
                axi_req.wdata = {4{cur_req.wdata[7:0]}};  // Byte in every lane
                lane_shift    = {cur_req.addr[1:0], 3'b000};
            end
            core_mem_pkg::SIZE_HALFWORD: begin
                axi_req.wstrb = cur_req.addr[1] ? 4'b1100 : 4'b0011;
                axi_req.wdata = {2{cur_req.wdata[15:0]}}; // Half in both halves
                lane_shift    = {cur_req.addr[1], 4'b0000};
            end
            default: begin
                axi_req.wstrb = 4'b1111;
                axi_req.wdata = cur_req.wdata;
                lane_shift    = 5'd0;
            end
        endcase
    end

    // Read lane down to bit 0, then zero-extend
    assign rd_shifted = axi_rsp.rdata >> lane_shift;

    always_comb begin
        unique case (cur_req.size)
            core_mem_pkg::SIZE_BYTE:     rd_data = {24'h0, rd_shifted[7:0]};
            core_mem_pkg::SIZE_HALFWORD: rd_data = {16'h0, rd_shifted[15:0]};
            default:                     rd_data = rd_shifted;
        endcase
    end

    // Ready pulse to the owner only, data fanned out to all
    always_comb begin
        for (int i = 0; i < NUM_REQUESTORS; i++) begin
            limp_rsp[i].ready = done && (grant_q == GNT_W'(i));
            limp_rsp[i].rdata = rd_data;
        end
    end

endmodule : core_axi_manager

//--- verilog/core_mem_subsys.sv
//**********************************************************
// Core memory subsystem
// Requestor ports through the AXI manager into the SRAM
//**********************************************************

`timescale 1ns/1ps

module core_mem_subsys #(
    parameter int NUM_REQUESTORS = 3,   // Walker, refill, uncached
    parameter int READ_LATENCY   = 2,   // SRAM cycles from AR to R
    parameter int MEM_WORDS      = 256  // SRAM depth in words
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  core_mem_pkg::limp_req_t limp_req [NUM_REQUESTORS-1:0],
    output core_mem_pkg::limp_rsp_t limp_rsp [NUM_REQUESTORS-1:0]
);

    // Single AXI link between manager and SRAM
    core_mem_pkg::axi_mreq_t axi_req;
    core_mem_pkg::axi_srsp_t axi_rsp;

    core_axi_manager #(
        .NUM_REQUESTORS (NUM_REQUESTORS)
    ) u_manager (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .limp_req (limp_req),
        .limp_rsp (limp_rsp),
        .axi_req  (axi_req),
        .axi_rsp  (axi_rsp)
    );

    axi_sram_slave #(
        .READ_LATENCY (READ_LATENCY),
        .MEM_WORDS    (MEM_WORDS)
    ) u_sram (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp)
    );

endmodule : core_mem_subsys

//--- sim/core_axi_manager_assert.sv
//**********************************************************
// AXI manager protocol assertions
// Valid hold, single ready pulse, strobes and read/write
// exclusion, bound onto every manager instance
//**********************************************************

`timescale 1ns/1ps

module core_axi_manager_assert #(
    parameter int NUM_REQUESTORS = 3
) (
    input logic                    i_clk,
    input logic                    i_rst_n,
    input core_mem_pkg::limp_rsp_t limp_rsp [NUM_REQUESTORS-1:0],
    input core_mem_pkg::axi_mreq_t axi_req,
    input core_mem_pkg::axi_srsp_t axi_rsp
);

    logic [NUM_REQUESTORS-1:0] ready_vec;

    always_comb begin
        for (int i = 0; i < NUM_REQUESTORS; i++) begin
            ready_vec[i] = limp_rsp[i].ready;
        end
    end

    // A valid may only drop once its ready was seen
    a_ar_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(axi_req.arvalid) |-> $past(axi_rsp.arready))
        else $error("arvalid dropped before arready");

    a_aw_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(axi_req.awvalid) |-> $past(axi_rsp.awready))
        else $error("awvalid dropped before awready");

    a_w_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(axi_req.wvalid) |-> $past(axi_rsp.wready))
        else $error("wvalid dropped before wready");

    a_one_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(ready_vec))
        else $error("several requestor readies in one cycle");

    a_wstrb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        axi_req.wvalid |-> axi_req.wstrb != 4'b0000)
        else $error("write beat with empty strobe");

    a_rw_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(axi_req.arvalid && (axi_req.awvalid || axi_req.wvalid)))
        else $error("read and write valid together");

endmodule : core_axi_manager_assert

bind core_axi_manager core_axi_manager_assert #(
    .NUM_REQUESTORS (NUM_REQUESTORS)
) u_assert (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .limp_rsp (limp_rsp),
    .axi_req  (axi_req),
    .axi_rsp  (axi_rsp)
);

//--- sim/tb_core_mem_subsys.sv
//************************************************************
// Memory subsystem testbench
// Replays grouped requestor transactions from a stimulus file,
// checks read data and the order of the ready pulses
//************************************************************

`timescale 1ns/1ps

module tb_core_mem_subsys;

    localparam int NUM_REQ      = 3;
    localparam int READ_LATENCY = 2;     // Same as the DUT default
    localparam int REC_FIELDS   = 7;
    localparam int MAX_RECS     = 64;
    localparam int END_GROUP    = 'hFF;  // Group number of the end marker
    localparam int F_GROUP      = 0;
    localparam int F_REQ        = 1;
    localparam int F_WRITE      = 2;
    localparam int F_SIZE       = 3;
    localparam int F_ADDR       = 4;
    localparam int F_WDATA      = 5;
    localparam int F_EXP        = 6;

    logic                    i_clk;
    logic                    i_rst_n;
    core_mem_pkg::limp_req_t limp_req [NUM_REQ-1:0];
    core_mem_pkg::limp_rsp_t limp_rsp [NUM_REQ-1:0];

    logic [31:0] stim [0:REC_FIELDS*MAX_RECS-1];
    int          num_recs;
    int          gap [0:MAX_RECS-1];     // Idle cycles after each group
    int          exp_order [$];          // Requestor expected at each ready pulse
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_cnt    = 0;
    int          cycle_limit  = 0;       // Zero until the stimulus is loaded

    core_mem_subsys DUT (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .limp_req (limp_req),
        .limp_rsp (limp_rsp)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: stimulus not finished after %0d cycles", cycle_cnt);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic int field(input int rec, input int f);
        return int'(stim[rec*REC_FIELDS + f]);
    endfunction

    // Next record of requestor r within [from, last], -1 if none
    function automatic int next_of(input int r, input int from, input int last);
        for (int i = from; i <= last; i++) begin
            if (field(i, F_REQ) == r) return i;
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("error: %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    // Service order of a group, lowest pending index wins each arbitration
    // A requestor just served sits out one idle cycle before its next record
    task automatic build_order(input int first, input int last);
        int nxt [NUM_REQ];
        int last_r;
        int pick;
        exp_order.delete();
        for (int r = 0; r < NUM_REQ; r++) nxt[r] = next_of(r, first, last);
        last_r = -1;
        do begin
            pick = -1;
            for (int r = 0; r < NUM_REQ; r++) begin
                if (pick < 0 && r != last_r && nxt[r] >= 0) pick = r;
            end
            if (pick < 0 && last_r >= 0 && nxt[last_r] >= 0) pick = last_r; // Only one left
            if (pick >= 0) begin
                exp_order.push_back(pick);
                nxt[pick] = next_of(pick, nxt[pick] + 1, last);
                last_r = pick;
            end
        end while (pick >= 0);
    endtask

    task automatic drive_record(input int r, input int rec);
        limp_req[r].valid    <= 1'b1;
        limp_req[r].wen_nren <= stim[rec*REC_FIELDS + F_WRITE][0];
        limp_req[r].size     <= core_mem_pkg::size_e'(stim[rec*REC_FIELDS + F_SIZE][1:0]);
        limp_req[r].addr     <= stim[rec*REC_FIELDS + F_ADDR];
        limp_req[r].wdata    <= stim[rec*REC_FIELDS + F_WDATA];
    endtask

    // All requestors of the group start together, each walks its own records
    task automatic run_group(input int first, input int last);
        int    cur [NUM_REQ];
        bit    active [NUM_REQ];
        int    pos;
        int    hits;
        string name;
        build_order(first, last);
        pos = 0;
        @(posedge i_clk);
        for (int r = 0; r < NUM_REQ; r++) begin
            cur[r]    = next_of(r, first, last);
            active[r] = (cur[r] >= 0);
            if (active[r]) drive_record(r, cur[r]);
        end
        while (pos < exp_order.size()) begin
            @(posedge i_clk);
            hits = 0;
            for (int r = 0; r < NUM_REQ; r++) begin
                if (limp_rsp[r].ready) begin
                    hits++;
                    if (!active[r]) begin
                        other_errors++;
                        $display("Ready pulse went to requestor %0d, which had no request", r);
                    end else begin
                        name = $sformatf("group %0d record %0d", field(cur[r], F_GROUP), cur[r]);
                        check_value({name, " ready order"}, exp_order[pos], r);
                        pos++;
                        if (field(cur[r], F_WRITE) == 0) begin  // Read data valid with ready
                            check_value({name, " read data"}, stim[cur[r]*REC_FIELDS + F_EXP],
                                        limp_rsp[r].rdata);
                        end
                        limp_req[r].valid <= 1'b0;
                        active[r] = 1'b0;
                        cur[r]    = next_of(r, cur[r] + 1, last);
                    end
                end else if (!active[r] && cur[r] >= 0) begin
                    drive_record(r, cur[r]); // Next record after one idle cycle
                    active[r] = 1'b1;
                end
            end
            if (hits > 1) begin
                other_errors++;
                $display("More than one requestor saw ready in the same cycle");
            end
        end
    endtask

    initial begin
        int first;
        int last;
        int grp;
        int gap_total;
        for (int r = 0; r < NUM_REQ; r++) limp_req[r] <= '0;
        i_rst_n <= 1'b0;
        void'($urandom(61));
        $readmemh("sim/mem_stimulus.hex", stim);
        num_recs = 0;
        while (num_recs < MAX_RECS && field(num_recs, F_GROUP) != END_GROUP) num_recs++;
        grp       = 0;
        gap_total = 0;
        for (int i = 0; i < num_recs; i++) begin
            if (i == 0 || field(i, F_GROUP) != field(i - 1, F_GROUP)) begin
                gap[grp]   = $urandom % 4;
                gap_total += gap[grp];
                grp++;
            end
        end
        cycle_limit = num_recs * (READ_LATENCY + 8) + gap_total + 50;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        if (num_recs == 0 || num_recs == MAX_RECS) begin
            other_errors++;
            $display("Stimulus file is missing, empty or has no end marker");
        end else begin
            first = 0;
            grp   = 0;
            while (first < num_recs) begin
                last = first;
                while (last + 1 < num_recs
                       && field(last + 1, F_GROUP) == field(first, F_GROUP)) begin
                    last++;
                end
                run_group(first, last);
                repeat (gap[grp]) @(posedge i_clk);
                grp++;
                first = last + 1;
            end
        end
        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_core_mem_subsys

//--- sim/mem_stimulus.hex
// Columns: group, requestor, write flag, size (0 byte, 1 half, 2 word), address, wdata, expected
// Records of one group start together; expected read data is used on reads only
01 2 1 2 00000010 CAFEF00D 00000000
01 2 0 2 00000010 00000000 CAFEF00D
02 1 1 0 00000020 00000011 00000000
02 1 1 0 00000021 00000022 00000000
02 1 1 0 00000022 00000033 00000000
02 1 1 0 00000023 00000044 00000000
02 1 0 2 00000020 00000000 44332211
02 1 0 0 00000020 00000000 00000011
02 1 0 0 00000021 00000000 00000022
02 1 0 0 00000022 00000000 00000033
02 1 0 0 00000023 00000000 00000044
03 0 1 1 00000030 0000BEEF 00000000
03 0 1 1 00000032 00001234 00000000
03 0 0 1 00000030 00000000 0000BEEF
03 0 0 1 00000032 00000000 00001234
03 0 0 2 00000030 00000000 1234BEEF
04 0 1 2 00000040 A0A0A0A0 00000000
04 0 1 2 00000044 B1B1B1B1 00000000
04 0 1 2 00000048 C2C2C2C2 00000000
05 2 0 2 00000048 00000000 C2C2C2C2
05 1 0 2 00000044 00000000 B1B1B1B1
05 0 0 2 00000040 00000000 A0A0A0A0
06 1 1 2 00000050 5A5A5A5A 00000000
06 2 1 2 00000054 0BADBEEF 00000000
06 1 0 2 00000050 00000000 5A5A5A5A
07 0 0 2 00000054 00000000 0BADBEEF
07 1 0 2 000000FC 00000000 00000000
07 2 0 2 00000410 00000000 CAFEF00D
FF 0 0 0 00000000 00000000 00000000

//--- compile.f
verilog/core_mem_pkg.sv
verilog/axi_sram_slave.sv
verilog/core_axi_manager.sv
verilog/core_mem_subsys.sv
sim/core_axi_manager_assert.sv
sim/tb_core_mem_subsys.sv

//--- Makefile
# Verilator build and run of the memory subsystem testbench

BIN := obj_dir/Vtb_core_mem_subsys

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

$(BIN): compile.f $(wildcard verilog/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --top-module tb_core_mem_subsys \
		-Mdir obj_dir -f compile.f

clean:
	rm -rf obj_dir
